//--- Bender.yml
package:
  name: mboot_sys

sources:
  # Synthesizable design
  - include_dirs:
      - common
    files:
      - common/mboot_pkg.sv
      - common/icap_if.sv
      - logic/icap_cfg_engine.sv
      - mboot/mboot_regs.sv
      - mboot/mboot_top.sv

  # Testbench and bound checker
  - target: test
    include_dirs:
      - common
    files:
      - dv/mboot_chk.sv
      - dv/mboot_tb.sv

//--- common/icap_if.sv
`timescale 1ns/10ps
`default_nettype none

interface icap_if;

	// Software side levels
	logic        icap_clk;
	logic        icap_ce_n;    // Active low enable
	logic        icap_write_n; // Low = write, high = read
	logic [15:0] icap_i;       // Byte bit-reversed

	// Engine side
	logic        busy;
	logic [15:0] icap_o;

	modport driver (
		output icap_clk, icap_ce_n, icap_write_n, icap_i,
		input  busy, icap_o
	);

	modport engine (
		input  icap_clk, icap_ce_n, icap_write_n, icap_i,
		output busy, icap_o
	);

endinterface

`default_nettype wire

//--- common/mboot_macros.svh
`ifndef MBOOT_MACROS_SVH
`define MBOOT_MACROS_SVH

////////////////////
// Bus widths
`define MBOOT_ADR_W     6
`define MBOOT_DAT_W     32
`define MBOOT_RDAT_W    19

// Register offsets
`define MBOOT_OFS_FLASH 6'h00
`define MBOOT_OFS_ICAPO 6'h04
`define MBOOT_OFS_ICAPI 6'h08

////////////////////
// Reset levels, {sck, cs, mosi, hold_n, wp_n} and {clk, ce_n, write_n, data}
`define MBOOT_FLASH_RST 5'b01011
`define MBOOT_ICAP_RST  19'h60000

////////////////////
// Configuration words
`define MBOOT_SYNC_WORD  16'hAA99
`define MBOOT_CMD_IPROG  16'h000E
`define MBOOT_CMD_DESYNC 16'h000D
`define MBOOT_NOOP       16'h2000
`define MBOOT_BOOT_W     24

`endif

//--- common/mboot_pkg.sv
`default_nettype none

package mboot_pkg;

	// Config register addresses, type-1 header bits [10:5]
	typedef enum logic [5:0] {
		CFG_CMD      = 6'h05,
		CFG_GENERAL1 = 6'h13,
		CFG_GENERAL2 = 6'h14
	} cfg_reg_t;

	typedef enum logic [1:0] {
		OP_NOP   = 2'b00,
		OP_READ  = 2'b01,
		OP_WRITE = 2'b10
	} cfg_op_t;

	typedef enum logic [1:0] {
		ST_UNSYNC,
		ST_HEADER,
		ST_WDATA,
		ST_RDATA
	} cfg_state_t;

	// Mirror bit order inside each byte of a port word
	function automatic logic [15:0] byte_rev16(input logic [15:0] w);
		logic [15:0] r;
		for (int i = 0; i < 8; i++) begin
			r[i]     = w[7-i];
			r[8+i]   = w[15-i];
		end
		return r;
	endfunction

endpackage

`default_nettype wire

//--- dv/mboot_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "mboot_macros.svh"

module mboot_chk (
	input  logic                     CLK_I,
	input  logic                     RST_I,
	input  logic                     cyc,
	input  logic                     stb,
	input  logic                     ack,
	input  logic                     reboot,
	input  logic                     spi_cs,
	input  logic                     spi_hold_n,
	input  logic                     spi_wp_n,
	input  logic [`MBOOT_BOOT_W-1:0] boot_addr
);

	int err_cnt = 0;

	////////////////////
	// Bus acknowledge
	ack_single: assert property (@(posedge CLK_I) disable iff (RST_I) ack |=> !ack)
		else begin
			$error("ack high in two consecutive cycles");
			err_cnt++;
		end

	ack_after_stb: assert property (@(posedge CLK_I) disable iff (RST_I)
		ack |-> $past(cyc && stb))
		else begin
			$error("ack without a sampled strobe");
			err_cnt++;
		end

	////////////////////
	// Reboot request
	reboot_pulse: assert property (@(posedge CLK_I) disable iff (RST_I) reboot |=> !reboot)
		else begin
			$error("reboot longer than one cycle");
			err_cnt++;
		end

	// Address only moves together with the pulse
	addr_hold: assert property (@(posedge CLK_I) disable iff (RST_I)
		!reboot |-> $stable(boot_addr))
		else begin
			$error("boot_addr changed without a reboot pulse");
			err_cnt++;
		end

	// From the second reset edge on, the flops have surely been cleared
	reset_state: assert property (@(posedge CLK_I)
		RST_I && $past(RST_I) |->
		(!ack && !reboot && spi_cs && spi_hold_n && spi_wp_n && boot_addr == '0))
		else begin
			$error("outputs not at reset values during reset");
			err_cnt++;
		end

endmodule

bind mboot_top mboot_chk i_chk (
	.CLK_I      (CLK_I),
	.RST_I      (RST_I),
	.cyc        (cyc),
	.stb        (stb),
	.ack        (ack),
	.reboot     (reboot),
	.spi_cs     (spi_cs),
	.spi_hold_n (spi_hold_n),
	.spi_wp_n   (spi_wp_n),
	.boot_addr  (boot_addr)
);

`default_nettype wire

//--- dv/mboot_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mboot_macros.svh"

module mboot_tb;

	localparam int ACK_TIMEOUT    = 20;
	localparam int REBOOT_TIMEOUT = 8;   // Cycles to watch for a pulse

	logic                     CLK_I;
	logic                     RST_I;
	logic                     cyc;
	logic                     stb;
	logic                     we;
	logic [`MBOOT_ADR_W-1:0]  adr;
	logic [`MBOOT_DAT_W-1:0]  dat_w;
	logic [3:0]               sel;
	logic                     ack;
	logic [`MBOOT_RDAT_W-1:0] dat_r;
	logic                     spi_sck;
	logic                     spi_cs;
	logic                     spi_mosi;
	logic                     spi_hold_n;
	logic                     spi_wp_n;
	logic                     spi_miso;
	logic                     reboot;
	logic [`MBOOT_BOOT_W-1:0] boot_addr;

	// Trace fields
	int                       fd;
	int                       code;
	int                       n_ops;
	logic [8*8-1:0]           tok;
	logic [`MBOOT_ADR_W-1:0]  t_ofs;
	logic [31:0]              t_data;
	logic                     t_miso;
	logic [31:0]              t_exp;
	string                    test_name;

	mboot_top i_dut (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.sel        (sel),
		.ack        (ack),
		.dat_r      (dat_r),
		.spi_sck    (spi_sck),
		.spi_cs     (spi_cs),
		.spi_mosi   (spi_mosi),
		.spi_hold_n (spi_hold_n),
		.spi_wp_n   (spi_wp_n),
		.spi_miso   (spi_miso),
		.reboot     (reboot),
		.boot_addr  (boot_addr)
	);

	always #2 CLK_I = ~CLK_I;  // 4 ns period

	////////////////////
	// Failure reporting
	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("** Error %s: expected %h, actual %h", name, exp, act);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1);
	endtask

	always @(negedge CLK_I) begin
		assert (i_dut.i_chk.err_cnt == 0)
			else report_failure("An assertion in the bound checker failed");
	end

	////////////////////
	// One bus transfer, returns read data and the pin levels seen with ack
	task automatic bus_cycle(input logic wr, input logic [`MBOOT_ADR_W-1:0] ofs,
			input logic [`MBOOT_DAT_W-1:0] data, input logic miso,
			output logic [`MBOOT_RDAT_W-1:0] rdata, output logic [4:0] pins);
		int cnt;
		bit seen;
		cnt  = 0;
		seen = 1'b0;
		@(posedge CLK_I);
		spi_miso <= miso;  // Settled before the slave samples
		cyc      <= 1'b1;
		stb      <= 1'b1;
		we       <= wr;
		adr      <= ofs;
		dat_w    <= data;
		sel      <= 4'hF;
		while (!seen && cnt < ACK_TIMEOUT) begin
			@(negedge CLK_I);
			seen = ack;
			cnt++;
		end
		assert (seen) else report_failure("Timed out waiting for ack from the bus slave");
		rdata = dat_r;
		pins  = {spi_sck, spi_cs, spi_mosi, spi_hold_n, spi_wp_n};
		@(posedge CLK_I);
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	// Either a pulse must come, or the whole window must pass without one
	task automatic wait_reboot(input bit expect_pulse, input logic [`MBOOT_BOOT_W-1:0] exp_addr);
		int cnt;
		bit seen;
		cnt  = 0;
		seen = 1'b0;
		while (!seen && cnt < REBOOT_TIMEOUT) begin
			@(negedge CLK_I);
			seen = reboot;
			cnt++;
		end
		if (expect_pulse)
			assert (seen) else report_failure("Timed out waiting for the reboot pulse");
		else
			assert (!seen) else report_failure("Reboot pulsed while it had to stay low");
		assert (boot_addr == exp_addr) else report_mismatch(test_name, exp_addr, boot_addr);
	endtask

	task automatic skip_line();
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1)
			ch = $fgetc(fd);
	endtask

	task automatic run_step();
		logic [`MBOOT_RDAT_W-1:0] rdata;
		logic [4:0]               pins;
		code = $fscanf(fd, "%h %h %h %h", t_ofs, t_data, t_miso, t_exp);
		assert (code == 4) else report_failure("Malformed line in the trace file");
		n_ops++;
		test_name = $sformatf("step %0d %c %h", n_ops, tok[7:0], t_ofs);
		if (tok == "W") begin
			bus_cycle(1'b1, t_ofs, t_data, t_miso, rdata, pins);
			if (t_ofs == `MBOOT_OFS_FLASH)
				assert (pins == t_data[4:0])
					else report_mismatch(test_name, t_data[4:0], pins);
		end else if (tok == "R") begin
			bus_cycle(1'b0, t_ofs, '0, t_miso, rdata, pins);
			assert (rdata == t_exp[`MBOOT_RDAT_W-1:0])
				else report_mismatch(test_name, t_exp[`MBOOT_RDAT_W-1:0], rdata);
		end else if (tok == "B") begin
			wait_reboot(t_data[0], t_exp[`MBOOT_BOOT_W-1:0]);
		end else begin
			report_failure("Unknown operation in the trace file");
		end
	endtask

	////////////////////
	// Main sequence
	initial begin
		CLK_I    = 1'b0;
		RST_I    = 1'b1;
		cyc      = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		adr      = '0;
		dat_w    = '0;
		sel      = 4'h0;
		spi_miso = 1'b0;
		n_ops    = 0;
		fd = $fopen("dv/mboot_trace.txt", "r");
		assert (fd != 0) else report_failure("Cannot open dv/mboot_trace.txt");

		repeat (5) @(posedge CLK_I);
		RST_I <= 1'b0;

		code = $fscanf(fd, "%s", tok);
		while (code == 1) begin
			if (tok == "#")
				skip_line();  // Comment line
			else
				run_step();
			code = $fscanf(fd, "%s", tok);
		end
		$fclose(fd);

		assert (n_ops > 0) else report_failure("The trace file held no transactions");
		@(negedge CLK_I);
		if (i_dut.i_chk.err_cnt == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			report_failure("An assertion in the bound checker failed");
		end
	end

endmodule

`default_nettype wire

//--- dv/mboot_trace.txt
# op ofs wdata miso expected (read data for R, boot address for B)
# B lines use wdata 1 for a pulse that must come, 0 for a window that must pass without one
# Reset values of pins and port register
R 00 00000000 1 0002B
R 00 00000000 0 0000B
R 04 00000000 0 60000
# Flash pin patterns and MISO in bit 5
W 00 00000015 0 00000
R 00 00000000 1 00035
W 00 FFFFFFEA 1 00000
R 00 00000000 0 0000A
R 00 00000000 1 0002A
W 00 0000001F 0 00000
R 00 00000000 0 0001F
W 00 0000000B 0 00000
R 00 00000000 1 0002B
# Port register reads back as written, upper write bits dropped
W 04 FFF7ABCD 0 00000
R 04 00000000 0 7ABCD
W 04 0003C35A 0 00000
R 04 00000000 0 3C35A
# Unmapped offset ignores writes and reads the port status
W 0C 12345678 0 00000
R 0C 00000000 0 00000
# CMD header and IPROG before sync
W 04 000030A1 0 00000
W 04 000430A1 0 00000
W 04 0000000E 0 00000
W 04 0004000E 0 00000
B 00 00000000 0 000000
# Sync, NOOP, GENERAL1, GENERAL2, IPROG
W 04 0000AA99 0 00000
W 04 0004AA99 0 00000
W 04 00002000 0 00000
W 04 00042000 0 00000
W 04 00003261 0 00000
W 04 00043261 0 00000
W 04 00001234 0 00000
W 04 00041234 0 00000
W 04 00003281 0 00000
W 04 00043281 0 00000
W 04 00000B5A 0 00000
W 04 00040B5A 0 00000
W 04 000030A1 0 00000
W 04 000430A1 0 00000
W 04 0000000E 0 00000
W 04 0004000E 0 00000
B 00 00000001 0 005A1234
# Readback of GENERAL1, busy on the first read edge
W 04 0000AA99 0 00000
W 04 0004AA99 0 00000
W 04 00002A61 0 00000
W 04 00042A61 0 00000
W 04 00010000 0 00000
W 04 00050000 0 00000
R 08 00000000 0 10000
W 04 00010000 0 00000
W 04 00050000 0 00000
R 08 00000000 0 01234
# DESYNC, then IPROG must not reboot
W 04 000030A1 0 00000
W 04 000430A1 0 00000
W 04 0000000D 0 00000
W 04 0004000D 0 00000
W 04 000030A1 0 00000
W 04 000430A1 0 00000
W 04 0000000E 0 00000
W 04 0004000E 0 00000
B 00 00000000 0 005A1234

//--- logic/icap_cfg_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "mboot_macros.svh"

module icap_cfg_engine
	import mboot_pkg::*;
(
	input  logic                     CLK_I,
	input  logic                     RST_I,

	icap_if.engine                   icap,

	output logic                     reboot,
	output logic [`MBOOT_BOOT_W-1:0] boot_addr
);

	cfg_state_t  state;
	cfg_reg_t    reg_sel;   // Register named by the last header
	logic        clk_d;
	logic        rise;
	logic        wr_edge;
	logic        rd_edge;
	logic        rd_first;
	logic [15:0] word;
	logic [15:0] general1;
	logic [15:0] general2;
	logic [15:0] cmd_q;
	logic        hdr_ok;
	cfg_op_t     hdr_op;
	cfg_reg_t    hdr_reg;

	////////////////////
	// Port clock edges
	assign rise    = icap.icap_clk & ~clk_d;
	assign wr_edge = rise & ~icap.icap_ce_n & ~icap.icap_write_n;
	assign rd_edge = rise & ~icap.icap_ce_n &  icap.icap_write_n;

	// Undo the per-byte mirroring
	assign word = byte_rev16(icap.icap_i);

	// Type-1 header, single word only
	assign hdr_op  = cfg_op_t'(word[12:11]);
	assign hdr_reg = cfg_reg_t'(word[10:5]);
	assign hdr_ok  = (word != `MBOOT_NOOP) && (word[15:13] == 3'b001) && (word[4:0] == 5'd1);

	////////////////////
	// Packet processor
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			state     <= ST_UNSYNC;
			reg_sel   <= CFG_CMD;
			clk_d     <= 1'b1;  // Port clock idles high
			rd_first  <= 1'b0;
			general1  <= '0;
			general2  <= '0;
			cmd_q     <= '0;
			reboot    <= 1'b0;
			boot_addr <= '0;
			icap.busy   <= 1'b0;
			icap.icap_o <= '0;
		end else begin
			clk_d  <= icap.icap_clk;
			reboot <= 1'b0;
			if (wr_edge) begin
				case (state)
					ST_UNSYNC: begin
						if (word == `MBOOT_SYNC_WORD)
							state <= ST_HEADER;
					end
					ST_WDATA: begin
						state <= ST_HEADER;
						case (reg_sel)
							CFG_GENERAL1: general1 <= word;
							CFG_GENERAL2: general2 <= word;  // Low byte is boot_addr[23:16]
							CFG_CMD: begin
								cmd_q <= word;
								if (word == `MBOOT_CMD_IPROG) begin
									boot_addr <= {general2[7:0], general1};
									reboot    <= 1'b1;
								end else if (word == `MBOOT_CMD_DESYNC) begin
									state <= ST_UNSYNC;
								end
							end
							default: ;
						endcase
					end
					default: begin
						// Header, also ends an unfinished readback
						state     <= ST_HEADER;
						icap.busy <= 1'b0;
						if (hdr_ok && hdr_op == OP_WRITE) begin
							state   <= ST_WDATA;
							reg_sel <= hdr_reg;
						end else if (hdr_ok && hdr_op == OP_READ) begin
							state    <= ST_RDATA;
							reg_sel  <= hdr_reg;
							rd_first <= 1'b1;
						end
					end
				endcase
			end else if (rd_edge && state == ST_RDATA) begin
				if (rd_first) begin
					icap.busy <= 1'b1;  // First edge only flags busy
					rd_first  <= 1'b0;
				end else begin
					icap.busy <= 1'b0;
					state     <= ST_HEADER;
					case (reg_sel)
						CFG_GENERAL1: icap.icap_o <= general1;
						CFG_GENERAL2: icap.icap_o <= general2;
						CFG_CMD:      icap.icap_o <= cmd_q;
						default:      icap.icap_o <= '0;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- mboot/mboot_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "mboot_macros.svh"

module mboot_regs
	import mboot_pkg::*;
(
	input  logic                     CLK_I,
	input  logic                     RST_I,

	input  logic                     cyc,
	input  logic                     stb,
	input  logic                     we,
	input  logic [`MBOOT_ADR_W-1:0]  adr,
	input  logic [`MBOOT_DAT_W-1:0]  dat_w,
	input  logic [3:0]               sel,   // Byte selects ignored, registers are word wide
	output logic                     ack,
	output logic [`MBOOT_RDAT_W-1:0] dat_r,

	output logic                     spi_sck,
	output logic                     spi_cs,
	output logic                     spi_mosi,
	output logic                     spi_hold_n,
	output logic                     spi_wp_n,
	input  logic                     spi_miso,

	icap_if.driver                   icap
);

	logic        req;
	logic        flash_we;
	logic        icapo_we;
	logic        rd_req;
	logic [4:0]  flash_q;  // {sck, cs, mosi, hold_n, wp_n}
	logic [18:0] icap_q;   // {clk, ce_n, write_n, data}

	////////////////////
	// Bus handshake
	assign req      = cyc & stb & ~ack;
	assign flash_we = req & we & (adr == `MBOOT_OFS_FLASH);
	assign icapo_we = req & we & (adr == `MBOOT_OFS_ICAPO);
	assign rd_req   = req & ~we;

	// Single cycle acknowledge
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			ack <= 1'b0;
		else
			ack <= req;
	end

	////////////////////
	// Flash pin levels
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			flash_q <= `MBOOT_FLASH_RST;
		else if (flash_we)
			flash_q <= dat_w[4:0];
	end

	assign {spi_sck, spi_cs, spi_mosi, spi_hold_n, spi_wp_n} = flash_q;

	////////////////////
	// Config port levels
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			icap_q <= `MBOOT_ICAP_RST;
		else if (icapo_we)
			icap_q <= dat_w[18:0];
	end

	assign icap.icap_clk     = icap_q[18];
	assign icap.icap_ce_n    = icap_q[17];
	assign icap.icap_write_n = icap_q[16];
	assign icap.icap_i       = byte_rev16(icap_q[15:0]); // Port wants bits mirrored per byte

	// Read mux, held through the ack cycle
	always_ff @(posedge CLK_I) begin
		if (rd_req) begin
			case (adr)
				`MBOOT_OFS_FLASH:
					dat_r <= {{(`MBOOT_RDAT_W-6){1'b0}}, spi_miso, flash_q};
				`MBOOT_OFS_ICAPO:
					dat_r <= icap_q;  // As written, before reversal
				`MBOOT_OFS_ICAPI:
					dat_r <= {2'b00, icap.busy, icap.icap_o};
				default:
					dat_r <= {2'b00, icap.busy, icap.icap_o}; // Unmapped reads the status
			endcase
		end
	end

endmodule

`default_nettype wire

//--- mboot/mboot_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mboot_macros.svh"

module mboot_top (
	input  logic                     CLK_I,
	input  logic                     RST_I,

	// Bus slave
	input  logic                     cyc,
	input  logic                     stb,
	input  logic                     we,
	input  logic [`MBOOT_ADR_W-1:0]  adr,
	input  logic [`MBOOT_DAT_W-1:0]  dat_w,
	input  logic [3:0]               sel,
	output logic                     ack,
	output logic [`MBOOT_RDAT_W-1:0] dat_r,

	// Config flash pins
	output logic                     spi_sck,
	output logic                     spi_cs,
	output logic                     spi_mosi,
	output logic                     spi_hold_n,
	output logic                     spi_wp_n,
	input  logic                     spi_miso,

	output logic                     reboot,
	output logic [`MBOOT_BOOT_W-1:0] boot_addr
);

	icap_if icap ();

	mboot_regs i_regs (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.sel        (sel),
		.ack        (ack),
		.dat_r      (dat_r),
		.spi_sck    (spi_sck),
		.spi_cs     (spi_cs),
		.spi_mosi   (spi_mosi),
		.spi_hold_n (spi_hold_n),
		.spi_wp_n   (spi_wp_n),
		.spi_miso   (spi_miso),
		.icap       (icap.driver)
	);

	// Stand-in for the device config port
	icap_cfg_engine i_engine (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.icap      (icap.engine),
		.reboot    (reboot),
		.boot_addr (boot_addr)
	);

endmodule

`default_nettype wire

//--- mboot_sys.f
+incdir+common
common/mboot_pkg.sv
common/icap_if.sv
logic/icap_cfg_engine.sv
mboot/mboot_regs.sv
mboot/mboot_top.sv
dv/mboot_chk.sv
dv/mboot_tb.sv
